// File: rtl/sdram_config.svh
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// command codes, {ras_n, cas_n, we_n}
`define CMD_NOOP 3'b111
`define CMD_PRCH 3'b010
`define CMD_MRST 3'b000
`define CMD_ARSR 3'b001
`define CMD_ACTV 3'b011
`define CMD_READ 3'b101
`define CMD_WRIT 3'b100

`define INIT_WAIT_CYCLES 1024 // cke held low
`define INIT_STEP_CYCLES 16 // spacing of table commands
`define INIT_SETTLE_CYCLES 256 // after the last table entry

`define MODE_REG_INIT 13'h120 // a8 set on first load, cl 2, bl 1
`define MODE_REG_FINAL 13'h020 // cl 2, sequential, bl 1
`define EXT_MODE_REG 13'h000

`define T_RCD 2
`define T_RP 2
`define T_WR 2
`define T_RFC 7
`define CAS_LATENCY 2
`define REFRESH_INTERVAL 390

`define ROW_BITS 13
`define COL_BITS 9
`define BANK_BITS 2
`define DATA_BITS 16

`endif

// File: rtl/sdram_pkg.sv
`include "sdram_config.svh"

package sdram_pkg;

	typedef logic [2:0] sdram_cmd_t; // {ras_n, cas_n, we_n}
	typedef logic [`ROW_BITS-1:0] sdram_row_t; // address pins
	typedef logic [`BANK_BITS-1:0] sdram_bank_t;
	typedef logic [`DATA_BITS-1:0] sdram_word_t;
	typedef logic [`BANK_BITS+`ROW_BITS+`COL_BITS-1:0] wb_addr_t; // bank, row, column

	typedef struct packed {
		sdram_cmd_t cmd;
		sdram_row_t addr;
		sdram_bank_t bank;
	} sdram_bus_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_addr_t adr;
		sdram_word_t dat; // write data
	} wb_req_t;

	typedef struct packed {
		logic ack;
		sdram_word_t dat; // read data
	} wb_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		ACTIVATE,
		RCD_WAIT,
		ACCESS,
		CL_WAIT,
		RECOVER,
		REFRESH,
		RFC_WAIT
	} seq_state_t;

endpackage

// File: rtl/initializer.sv
`include "sdram_config.svh"

module initializer
(
	input logic CLK_n,
	input logic RST,
	input sdram_pkg::sdram_bus_t user_cmd,
	output sdram_pkg::sdram_bus_t pins,
	output logic cke,
	output logic init_done
);
	import sdram_pkg::*;

	localparam int WAIT_W = $clog2(`INIT_WAIT_CYCLES + 1);
	localparam int STEP_W = $clog2(`INIT_STEP_CYCLES + 1);
	localparam int SETTLE_W = $clog2(`INIT_SETTLE_CYCLES + 1);

	logic [WAIT_W-1:0] wait_cnt;
	logic [STEP_W-1:0] step_cnt; // intercommand spacing
	logic [SETTLE_W-1:0] settle_cnt;
	logic [2:0] stage; // table index
	logic table_done;
	logic step_due;
	sdram_bus_t rom_cmd;
	sdram_bus_t init_cmd;

	assign step_due = (step_cnt == STEP_W'(`INIT_STEP_CYCLES - 1));
	assign pins = init_done ? user_cmd : init_cmd; // user side owns pins after init

	// power-up command table
	always_comb
	begin
		rom_cmd.cmd = `CMD_NOOP;
		rom_cmd.addr = '0;
		rom_cmd.addr[10] = 1'b1; // all banks on precharge
		rom_cmd.bank = '0;
		case (stage)
		3'd0: rom_cmd.cmd = `CMD_PRCH;
		3'd1:
		begin
			rom_cmd.cmd = `CMD_MRST;
			rom_cmd.addr = `EXT_MODE_REG;
			rom_cmd.bank = sdram_bank_t'(1); // extended mode register
		end
		3'd2:
		begin
			rom_cmd.cmd = `CMD_MRST;
			rom_cmd.addr = `MODE_REG_INIT;
		end
		3'd3: rom_cmd.cmd = `CMD_PRCH;
		3'd4: rom_cmd.cmd = `CMD_ARSR;
		3'd5: rom_cmd.cmd = `CMD_ARSR;
		3'd6:
		begin
			rom_cmd.cmd = `CMD_MRST;
			rom_cmd.addr = `MODE_REG_FINAL;
		end
		default: rom_cmd.cmd = `CMD_NOOP; // entry 7 closes the table
		endcase
	end

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			cke <= 1'b0;
			init_done <= 1'b0;
			wait_cnt <= '0;
			step_cnt <= '0;
			settle_cnt <= '0;
			stage <= '0;
			table_done <= 1'b0;
			init_cmd.cmd <= `CMD_NOOP;
			init_cmd.addr <= '0;
			init_cmd.bank <= '0;
		end
		else if (!cke)
		begin
			wait_cnt <= wait_cnt + 1'b1;
			if (wait_cnt == WAIT_W'(`INIT_WAIT_CYCLES - 1))
				cke <= 1'b1;
		end
		else if (!table_done)
		begin
			if (step_due)
			begin
				init_cmd <= rom_cmd; // one cycle per entry
				stage <= stage + 3'd1;
				step_cnt <= '0;
				if (stage == 3'd7)
					table_done <= 1'b1;
			end
			else
			begin
				init_cmd.cmd <= `CMD_NOOP;
				step_cnt <= step_cnt + 1'b1;
			end
		end
		else if (!init_done)
		begin
			init_cmd.cmd <= `CMD_NOOP;
			settle_cnt <= settle_cnt + 1'b1;
			if (settle_cnt == SETTLE_W'(`INIT_SETTLE_CYCLES - 1))
				init_done <= 1'b1; // releases the user side
		end
	end

endmodule

// File: rtl/refresh_timer.sv
`include "sdram_config.svh"

module refresh_timer
(
	input logic CLK_n,
	input logic RST,
	input logic init_done,
	input logic ref_ack,
	output logic ref_req
);
	localparam int INTV_W = $clog2(`REFRESH_INTERVAL + 1);

	logic [INTV_W-1:0] intv_cnt;
	logic [1:0] pending; // saturates at 3
	logic tick;
	logic inc;
	logic dec;

	assign tick = init_done && (intv_cnt == INTV_W'(`REFRESH_INTERVAL - 1));
	assign inc = tick && (pending != 2'b11);
	assign dec = ref_ack && (pending != 2'b00);
	assign ref_req = (pending != 2'b00);

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			intv_cnt <= '0;
			pending <= 2'b00;
		end
		else
		begin
			if (init_done)
				intv_cnt <= tick ? '0 : intv_cnt + 1'b1;
			if (inc && !dec)
				pending <= pending + 2'b01;
			else if (dec && !inc)
				pending <= pending - 2'b01; // both at once cancel
		end
	end

endmodule

// File: rtl/command_sequencer.sv
`include "sdram_config.svh"

module command_sequencer
(
	input logic CLK_n,
	input logic RST,
	input logic init_done,
	input sdram_pkg::wb_req_t wb_req,
	output sdram_pkg::wb_rsp_t wb_rsp,
	input logic ref_req,
	output logic ref_ack,
	output sdram_pkg::sdram_bus_t user_cmd,
	output sdram_pkg::sdram_word_t dq_out,
	output logic dq_oe,
	input sdram_pkg::sdram_word_t dq_in
);
	import sdram_pkg::*;

	localparam int WAIT_W = 4;

	seq_state_t state;
	logic [WAIT_W-1:0] wait_cnt; // shared by all timing waits
	logic wait_done;
	logic strobe;
	logic ack_q;
	sdram_word_t rd_data;
	sdram_bank_t acc_bank;
	sdram_row_t acc_row;
	logic [`COL_BITS-1:0] acc_col;

	// master holds adr, we and dat until ack
	assign {acc_bank, acc_row, acc_col} = wb_req.adr;
	assign strobe = wb_req.cyc && wb_req.stb && !ack_q; // stb still high in ack cycle
	assign wait_done = (wait_cnt <= WAIT_W'(1));

	assign ref_ack = (state == REFRESH); // one cycle, with the ARSR
	assign dq_oe = (state == ACCESS) && wb_req.we;
	assign dq_out = wb_req.dat;
	assign wb_rsp = '{ack: ack_q, dat: rd_data};

	always_comb
	begin
		user_cmd.cmd = `CMD_NOOP;
		user_cmd.addr = '0;
		user_cmd.bank = '0;
		case (state)
		ACTIVATE:
		begin
			user_cmd.cmd = `CMD_ACTV;
			user_cmd.addr = acc_row;
			user_cmd.bank = acc_bank;
		end
		ACCESS:
		begin
			user_cmd.cmd = wb_req.we ? `CMD_WRIT : `CMD_READ;
			user_cmd.addr[`COL_BITS-1:0] = acc_col;
			user_cmd.addr[10] = 1'b1; // auto-precharge
			user_cmd.bank = acc_bank;
		end
		REFRESH: user_cmd.cmd = `CMD_ARSR;
		default: user_cmd.cmd = `CMD_NOOP;
		endcase
	end

	always_ff @(posedge CLK_n)
	begin
		if (!RST)
		begin
			state <= IDLE;
			wait_cnt <= '0;
			ack_q <= 1'b0;
		end
		else
		begin
			ack_q <= 1'b0;
			case (state)
			IDLE:
			begin
				if (init_done && ref_req)
					state <= REFRESH; // refresh wins over a waiting strobe
				else if (init_done && strobe)
					state <= ACTIVATE;
			end
			ACTIVATE:
			begin
				wait_cnt <= WAIT_W'(`T_RCD - 1);
				state <= RCD_WAIT;
			end
			RCD_WAIT:
			begin
				if (wait_done)
					state <= ACCESS;
				else
					wait_cnt <= wait_cnt - 1'b1;
			end
			ACCESS:
			begin
				if (wb_req.we)
				begin
					wait_cnt <= WAIT_W'(`T_WR + `T_RP - 1); // write recovery, then precharge
					state <= RECOVER;
				end
				else
				begin
					wait_cnt <= WAIT_W'(`CAS_LATENCY);
					state <= CL_WAIT;
				end
			end
			CL_WAIT:
			begin
				if (wait_done)
				begin
					wait_cnt <= WAIT_W'(`T_RP - 1);
					state <= RECOVER;
				end
				else
					wait_cnt <= wait_cnt - 1'b1;
			end
			RECOVER:
			begin
				if (wait_done)
				begin
					ack_q <= 1'b1;
					state <= IDLE;
				end
				else
					wait_cnt <= wait_cnt - 1'b1;
			end
			REFRESH:
			begin
				wait_cnt <= WAIT_W'(`T_RFC - 1);
				state <= RFC_WAIT;
			end
			RFC_WAIT:
			begin
				if (wait_done)
					state <= IDLE;
				else
					wait_cnt <= wait_cnt - 1'b1;
			end
			default: state <= IDLE;
			endcase
		end
	end

	// read word sampled cas latency after READ
	always_ff @(posedge CLK_n)
	begin
		if (state == CL_WAIT && wait_done)
			rd_data <= dq_in;
	end

endmodule

// File: rtl/sdram_ctrl.sv
module sdram_ctrl
(
	input logic CLK_n,
	input logic RST,
	input sdram_pkg::wb_req_t wb_req,
	output sdram_pkg::wb_rsp_t wb_rsp,
	output sdram_pkg::sdram_bus_t pins,
	output logic cke,
	output sdram_pkg::sdram_word_t dq_out,
	output logic dq_oe,
	input sdram_pkg::sdram_word_t dq_in
);
	import sdram_pkg::*;

	sdram_bus_t user_cmd; // sequencer to pin mux
	logic init_done;
	logic ref_req;
	logic ref_ack;

	initializer initializer_i
	(
		.CLK_n(CLK_n),
		.RST(RST),
		.user_cmd(user_cmd),
		.pins(pins),
		.cke(cke),
		.init_done(init_done)
	);

	refresh_timer refresh_timer_i
	(
		.CLK_n(CLK_n),
		.RST(RST),
		.init_done(init_done),
		.ref_ack(ref_ack),
		.ref_req(ref_req)
	);

	command_sequencer command_sequencer_i
	(
		.CLK_n(CLK_n),
		.RST(RST),
		.init_done(init_done), // run enable
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.ref_req(ref_req),
		.ref_ack(ref_ack),
		.user_cmd(user_cmd),
		.dq_out(dq_out),
		.dq_oe(dq_oe),
		.dq_in(dq_in)
	);

endmodule

// File: verification/sdram_checker.sv
`include "sdram_config.svh"

module sdram_checker
(
	input logic CLK_n,
	input logic RST,
	input sdram_pkg::wb_req_t wb_req,
	input sdram_pkg::wb_rsp_t wb_rsp,
	input sdram_pkg::sdram_bus_t pins,
	input logic cke,
	input sdram_pkg::sdram_word_t dq_out,
	input logic dq_oe,
	input logic init_done,
	input logic run_done,
	output int error_total
);
	import sdram_pkg::*;

	localparam int ACCESS_MAX = 2 + `T_RCD + `CAS_LATENCY + `T_WR + `T_RP;
	localparam int REF_LIMIT = `REFRESH_INTERVAL + ACCESS_MAX; // longest ARSR gap

	sdram_word_t shadow [wb_addr_t]; // last word written per address
	string names [6] = '{"init_wait", "init_table", "read_data", "access_cmds", "refresh",
		"ack_protocol"};
	int checks [6] = '{0, 0, 0, 0, 0, 0};
	int errs [6] = '{0, 0, 0, 0, 0, 0};
	int low_cycles = 0; // cycles with cke low after reset
	int table_idx = 0;
	int ref_gap = 0;
	int strobes = 0;
	int acks = 0;
	logic in_access = 1'b0;
	logic saw_act = 1'b0;
	logic saw_rw = 1'b0;
	logic ack_prev = 1'b0;
	logic cke_seen = 1'b0;
	logic done_seen = 1'b0;
	sdram_bus_t exp_cmd;
	sdram_bank_t adr_bank;
	sdram_row_t adr_row;
	logic [`COL_BITS-1:0] adr_col;

	initial error_total = 0;

	// init table as the memory expects it
	function automatic sdram_bus_t table_entry(input int idx);
		sdram_bus_t e;
		e.cmd = `CMD_NOOP;
		e.addr = 13'h400; // a10 for precharge-all
		e.bank = '0;
		case (idx)
		0, 3: e.cmd = `CMD_PRCH;
		1:
		begin
			e.cmd = `CMD_MRST;
			e.addr = `EXT_MODE_REG;
			e.bank = 2'd1;
		end
		2:
		begin
			e.cmd = `CMD_MRST;
			e.addr = `MODE_REG_INIT;
		end
		4, 5: e.cmd = `CMD_ARSR;
		6:
		begin
			e.cmd = `CMD_MRST;
			e.addr = `MODE_REG_FINAL;
		end
		default: e.cmd = `CMD_NOOP;
		endcase
		return e;
	endfunction

	task automatic fail(input int idx, input string what);
		errs[idx]++;
		error_total++;
		$display("test %s failed at t=%0t: %s", names[idx], $time, what);
	endtask

	task automatic check_eq(input int idx, input string sig, input logic [31:0] exp,
		input logic [31:0] got);
		checks[idx]++;
		if (exp !== got)
		begin
			errs[idx]++;
			error_total++;
			$display("ERROR t=%0t %s expected %0h got %0h", $time, sig, exp, got);
		end
	endtask

	task automatic report(input int idx);
		$display("test %s: %0d checks, %0d errors", names[idx], checks[idx], errs[idx]);
	endtask

	always @(posedge CLK_n)
	begin
		{adr_bank, adr_row, adr_col} = wb_req.adr;
		if (RST)
		begin
			if (!cke)
			begin
				check_eq(0, "pins.cmd", `CMD_NOOP, pins.cmd); // idle while cke low
				low_cycles++;
			end
			else if (!cke_seen)
			begin
				cke_seen = 1'b1;
				checks[0]++;
				if (low_cycles < `INIT_WAIT_CYCLES)
					fail(0, "cke rose before the power-up wait ended");
			end
			if (!init_done && pins.cmd !== `CMD_NOOP)
			begin
				exp_cmd = table_entry(table_idx);
				check_eq(1, "pins.cmd", exp_cmd.cmd, pins.cmd);
				check_eq(1, "pins.bank", exp_cmd.bank, pins.bank);
				if (exp_cmd.cmd == `CMD_MRST)
					check_eq(1, "pins.addr", exp_cmd.addr, pins.addr);
				else if (exp_cmd.cmd == `CMD_PRCH)
					check_eq(1, "pins.addr[10]", 1, pins.addr[10]);
				table_idx++;
			end
			else if (init_done && !done_seen)
			begin
				done_seen = 1'b1;
				checks[1]++;
				if (table_idx != 7)
					fail(1, "init_done rose before the whole command table");
				report(0);
				report(1);
			end
			if (init_done)
			begin
				ref_gap++;
				case (pins.cmd)
				`CMD_ARSR:
				begin
					checks[4]++;
					if (in_access && saw_act)
						fail(4, "auto-refresh issued inside an open access");
					ref_gap = 0;
				end
				`CMD_ACTV:
				begin
					if (!in_access || saw_act)
						fail(3, "ACT without a waiting strobe");
					check_eq(3, "pins.bank", adr_bank, pins.bank);
					check_eq(3, "pins.addr", adr_row, pins.addr);
					saw_act = 1'b1;
				end
				`CMD_READ, `CMD_WRIT:
				begin
					if (!saw_act || saw_rw)
						fail(3, "READ or WRITE without a preceding ACT");
					check_eq(3, "pins.cmd", wb_req.we ? `CMD_WRIT : `CMD_READ, pins.cmd);
					check_eq(3, "pins.addr[8:0]", adr_col, pins.addr[`COL_BITS-1:0]);
					check_eq(3, "pins.addr[10]", 1, pins.addr[10]);
					check_eq(3, "pins.bank", adr_bank, pins.bank);
					check_eq(3, "dq_oe", wb_req.we, dq_oe); // driven on writes only
					if (pins.cmd == `CMD_WRIT)
						check_eq(3, "dq_out", wb_req.dat, dq_out);
					saw_rw = 1'b1;
				end
				default: ;
				endcase
				if (ref_gap > REF_LIMIT)
				begin
					fail(4, "no auto-refresh within the refresh window");
					ref_gap = 0;
				end
			end
			if (wb_rsp.ack)
			begin
				checks[5]++;
				if (!(wb_req.cyc && wb_req.stb))
					fail(5, "ack without cyc and stb");
				if (ack_prev)
					fail(5, "ack held longer than one cycle");
				checks[3]++;
				if (!saw_act || !saw_rw)
					fail(3, "ack before ACT and READ or WRITE");
				if (wb_req.we)
					shadow[wb_req.adr] = wb_req.dat;
				else if (shadow.exists(wb_req.adr))
					check_eq(2, "wb_rsp.dat", shadow[wb_req.adr], wb_rsp.dat);
				acks++;
				in_access = 1'b0;
			end
			else if (wb_req.cyc && wb_req.stb && !in_access)
			begin
				in_access = 1'b1; // new strobe
				saw_act = 1'b0;
				saw_rw = 1'b0;
				strobes++;
			end
			ack_prev = wb_rsp.ack;
		end
	end

	always @(posedge run_done)
	begin
		checks[5]++;
		if (strobes != acks || in_access)
			fail(5, "strobe count and ack count differ");
		if (!done_seen)
			fail(1, "init_done never rose");
		for (int i = 2; i < 6; i++)
			report(i);
		$display("checker: %0d accesses, %0d errors", acks, error_total);
	end

endmodule

// File: verification/sdram_ctrl_tb.sv
`include "sdram_config.svh"

module sdram_ctrl_tb;
	import sdram_pkg::*;

	localparam int N_ACCESS = 200;
	localparam int MAX_GAP = 5;
	localparam int WORST = 4 + `T_RCD + `CAS_LATENCY + `T_WR + `T_RP + `T_RFC + MAX_GAP;
	localparam int CYCLE_LIMIT = `INIT_WAIT_CYCLES + 8 * `INIT_STEP_CYCLES
		+ `INIT_SETTLE_CYCLES + N_ACCESS * 2 * WORST + 20;

	logic CLK_n;
	logic RST;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	sdram_bus_t pins;
	logic cke;
	sdram_word_t dq_out;
	logic dq_oe;
	sdram_word_t dq_in;
	logic init_done;
	logic run_done;
	int error_total;
	int cycles = 0;

	sdram_word_t mem [wb_addr_t]; // memory device contents
	sdram_row_t open_row [4];
	int rd_cnt = 0;
	sdram_word_t rd_word;
	wb_addr_t model_addr;
	wb_addr_t written [$];
	logic acc_we;
	wb_addr_t acc_adr;
	sdram_word_t acc_dat;

	assign init_done = sdram_ctrl_i.init_done;

	sdram_ctrl sdram_ctrl_i
	(
		.CLK_n(CLK_n),
		.RST(RST),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.pins(pins),
		.cke(cke),
		.dq_out(dq_out),
		.dq_oe(dq_oe),
		.dq_in(dq_in)
	);

	sdram_checker sdram_checker_i
	(
		.CLK_n(CLK_n),
		.RST(RST),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.pins(pins),
		.cke(cke),
		.dq_out(dq_out),
		.dq_oe(dq_oe),
		.init_done(init_done),
		.run_done(run_done),
		.error_total(error_total)
	);

	// unwritten words read back a pattern of the full address
	function automatic sdram_word_t fill_word(input wb_addr_t a);
		return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'hc3a5;
	endfunction

	initial
	begin
		CLK_n = 1'b0;
		forever #10 CLK_n = ~CLK_n;
	end

	// behavioral sdram, data out cas latency after READ
	always @(posedge CLK_n)
	begin
		model_addr = {pins.bank, open_row[pins.bank], pins.addr[`COL_BITS-1:0]};
		if (rd_cnt != 0)
			rd_cnt--;
		case (pins.cmd)
		`CMD_ACTV: open_row[pins.bank] = pins.addr;
		`CMD_WRIT:
		begin
			if (dq_oe)
				mem[model_addr] = dq_out;
		end
		`CMD_READ:
		begin
			rd_word = mem.exists(model_addr) ? mem[model_addr] : fill_word(model_addr);
			rd_cnt = `CAS_LATENCY;
		end
		default: ;
		endcase
		#2;
		dq_in = (rd_cnt == 1) ? rd_word : sdram_word_t'($urandom); // noise outside the window
	end

	always @(posedge CLK_n)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic wb_access(input logic we, input wb_addr_t adr, input sdram_word_t dat);
		@(posedge CLK_n);
		#2;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		do
			@(posedge CLK_n);
		while (!wb_rsp.ack);
		#2;
		wb_req.cyc = 1'b0; // drop after the ack cycle
		wb_req.stb = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h2357_23d9));
		RST = 1'b0;
		wb_req = '0;
		dq_in = '0;
		run_done = 1'b0;
		repeat (4) @(posedge CLK_n);
		#2;
		RST = 1'b1;
		while (!init_done)
			@(posedge CLK_n);
		for (int i = 0; i < N_ACCESS; i++)
		begin
			acc_we = ($urandom_range(99) < 50) || (written.size() == 0);
			if (!acc_we && $urandom_range(99) < 80)
				acc_adr = written[$urandom_range(written.size() - 1)]; // read back
			else if (acc_we && written.size() != 0 && $urandom_range(99) < 30)
				acc_adr = written[$urandom_range(written.size() - 1)]; // overwrite
			else
				acc_adr = wb_addr_t'($urandom);
			acc_dat = sdram_word_t'($urandom);
			wb_access(acc_we, acc_adr, acc_dat);
			if (acc_we)
				written.push_back(acc_adr);
			repeat ($urandom_range(MAX_GAP)) @(posedge CLK_n);
		end
		repeat (4) @(posedge CLK_n);
		run_done = 1'b1;
		@(posedge CLK_n);
		#1;
		if (error_total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: sdram_ctrl.f
+incdir+rtl
rtl/sdram_pkg.sv
rtl/initializer.sv
rtl/refresh_timer.sv
rtl/command_sequencer.sv
rtl/sdram_ctrl.sv
verification/sdram_checker.sv
verification/sdram_ctrl_tb.sv
